// ==== ddr3_seq.f ====
verilog/ddr3_seq_pkg.sv
verilog/seq_ctrl_port.sv
verilog/seq_cmd_mem.sv
verilog/seq_fetch.sv
verilog/seq_cmd_decode.sv
verilog/seq_wbuf_delay.sv
verilog/ddr3_seq_top.sv
test/ddr3_seq_assert.sv
test/tb_ddr3_seq.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the ddr3_seq testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f ddr3_seq.f --top-module tb_ddr3_seq

out=$(./obj_dir/Vtb_ddr3_seq || true)
echo "$out"

if echo "$out" | grep -q "NO ERRORS"; then
    exit 0
else
    exit 1
fi

// ==== test/ddr3_seq_assert.sv ====
`timescale 1ns/1ns

module ddr3_seq_assert (
    input logic mclk,
    input logic rst,
    input logic cmda_en_i,
    input logic run_busy_i,
    input logic run_done_i,
    input logic mcontr_reset_i,
    input logic sd_ras_i,
    input logic sd_cas_i,
    input logic sd_we_i
);

    assert property (@(posedge mclk) disable iff (rst) run_done_i |-> run_busy_i)
        else $error("run_done_o pulsed while not busy");
    assert property (@(posedge mclk) disable iff (rst) run_done_i |=> !run_done_i)
        else $error("run_done_o longer than one cycle");
    // pins are registered, so nop shows one edge after the enable is sampled low
    assert property (@(posedge mclk) disable iff (rst)
        !cmda_en_i |=> {sd_ras_i, sd_cas_i, sd_we_i} == 3'b111)
        else $error("command pins not nop with cmda disabled");
    assert property (@(posedge mclk) disable iff (rst) mcontr_reset_i |=> !run_busy_i)
        else $error("run_busy_o high during memory reset");

endmodule

bind ddr3_seq_top ddr3_seq_assert assert_i (
    .mclk(mclk), .rst(rst), .cmda_en_i(cmda_en), .run_busy_i(run_busy_o),
    .run_done_i(run_done_o), .mcontr_reset_i(mcontr_reset_o),
    .sd_ras_i(sd_ras_o), .sd_cas_i(sd_cas_o), .sd_we_i(sd_we_o));

// ==== test/tb_ddr3_seq.sv ====
`timescale 1ns/1ns

module tb_ddr3_seq;
    import ddr3_seq_pkg::*;

    localparam int TBL_N = 24;                             // sequence table rows
    localparam int T_MAX = 256;                            // model cycles per run

    logic                  mclk, rst, cmd_stb_i, mem_we_i, run_refresh_i, run_seq_i;
    logic [7:0]            cmd_ad_i;
    logic [SEQ_ADDR_W:0]   mem_addr_i, run_addr_i;
    logic [CMD_W-1:0]      mem_data_i;
    logic [CHN_W-1:0]      run_chn_i, ext_buf_rchn_o, ext_buf_wchn_o;
    logic                  run_busy_o, run_done_o, mcontr_reset_o, sdrst_o, sd_cke_o;
    logic                  sd_ras_o, sd_cas_o, sd_we_o;
    logic [SD_BA_W-1:0]    sd_ba_o;
    logic [SD_ADDR_W-1:0]  sd_a_o;
    logic                  ext_buf_rd_o, ext_buf_page_nxt_o, ext_buf_rpage_nxt_o;
    logic                  ext_buf_rrefresh_o, ext_buf_rrun_o;
    logic                  ext_buf_wr_o, ext_buf_wpage_nxt_o, ext_buf_wrefresh_o, ext_buf_wrun_o;

    // table rows hold word, expected op, bank, address and flags {done, pause, rd, wr, rst}
    logic [CMD_W-1:0]      tbl_word [TBL_N];
    logic [2:0]            tbl_op [TBL_N];
    logic [2:0]            tbl_ba [TBL_N];
    logic [14:0]           tbl_a [TBL_N];
    logic [4:0]            tbl_flg [TBL_N];
    int                    tbl_cnt;

    logic [2:0]            e_op [T_MAX];                   // model indexed by cycle of the run
    logic [2:0]            e_ba [T_MAX];
    logic [14:0]           e_a [T_MAX];
    logic                  e_rd [T_MAX], e_pg [T_MAX], e_rpg [T_MAX];
    logic                  e_wr [T_MAX], e_wpg [T_MAX], e_done [T_MAX];
    int                    done_t;
    logic                  mode_m;                         // memory read mode model
    int                    err_cnt;
    int                    s_addr;

    ddr3_seq_top dut_i (.*);

    initial begin
        mclk = 1'b0;
        forever #4 mclk = ~mclk;
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            err_cnt++;
            $display("FAILED %0t ns: %s is %0h, expected %0h", $time, what, got, exp);
            $display("ERRORS FOUND");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        $display("ERRORS FOUND");
        $fatal(1, "stopped on timeout");
    endtask

    task automatic add_row(input logic [2:0] op, input logic [2:0] ba, input logic [14:0] a,
                           input logic rd, input logic wr, input logic pg, input logic ap);
        tbl_word[tbl_cnt] = {op, ba, a, rd, wr, pg, ap, 7'h00};
        tbl_op[tbl_cnt]   = op;
        tbl_ba[tbl_cnt]   = ba;
        tbl_a[tbl_cnt]    = a;
        tbl_flg[tbl_cnt]  = {op == OP_NOP && a[10], ap, rd, wr, pg};
        tbl_cnt++;
    endtask

    task automatic nop_row(input logic [9:0] len, input logic done);
        add_row(OP_NOP, 3'd0, {4'h0, done, len}, 1'b0, 1'b0, 1'b0, 1'b0);
    endtask

    task automatic load_table();
        tbl_cnt = 0;
        add_row(OP_ACT, 3'd2, 15'h1234, 0, 0, 0, 0);       // seq a from row 0
        add_row(OP_WR,  3'd2, 15'h0040, 0, 0, 0, 1);
        nop_row(10'(1 + $urandom % 6), 1'b0);
        add_row(OP_RD,  3'd2, 15'h0048, 0, 0, 0, 0);
        add_row(OP_PRE, 3'd2, 15'h0400, 0, 0, 0, 1);
        nop_row(10'd0, 1'b0);
        add_row(OP_REF, 3'd0, 15'h0000, 0, 0, 0, 0);
        nop_row(10'd0, 1'b1);
        add_row(OP_MRS, 3'd3, 15'h00a5, 0, 0, 0, 0);       // seq b from row 8
        add_row(OP_ZQ,  3'd0, 15'h0400, 0, 0, 0, 1);
        nop_row(10'(1 + $urandom % 6), 1'b0);
        add_row(OP_ACT, 3'd5, 15'h7f01, 0, 0, 0, 0);
        nop_row(10'($urandom % 6), 1'b1);
        add_row(OP_ACT, 3'd1, 15'h0100, 0, 0, 0, 0);       // seq c from row 13 with strobes
        add_row(OP_WR,  3'd1, 15'h0008, 0, 1, 1, 0);
        add_row(OP_WR,  3'd1, 15'h0010, 0, 1, 0, 0);
        nop_row(10'd2, 1'b0);
        add_row(OP_RD,  3'd1, 15'h0008, 1, 0, 1, 0);
        add_row(OP_RD,  3'd1, 15'h0010, 1, 0, 0, 0);
        nop_row(10'd0, 1'b1);
        add_row(OP_ACT, 3'd4, 15'h0200, 0, 0, 0, 0);       // seq d from row 20 with long pause
        nop_row(10'd200, 1'b0);
        nop_row(10'd0, 1'b1);
    endtask

    task automatic load_mem(input logic [SEQ_ADDR_W:0] addr, input int row0, input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge mclk);
            mem_we_i   <= 1'b1;
            mem_addr_i <= addr + (SEQ_ADDR_W+1)'(i);
            mem_data_i <= tbl_word[row0 + i];
        end
        @(posedge mclk);
        mem_we_i <= 1'b0;
    endtask

    // byte-serial write with data bytes only for the 16-bit group
    task automatic write_cmd(input logic [15:0] addr, input logic [15:0] data, input logic w16);
        @(posedge mclk);
        cmd_stb_i <= 1'b1;
        cmd_ad_i  <= addr[7:0];
        @(posedge mclk);
        cmd_stb_i <= 1'b0;
        cmd_ad_i  <= addr[15:8];
        if (w16) begin
            @(posedge mclk);
            cmd_ad_i <= data[7:0];
            @(posedge mclk);
            cmd_ad_i <= data[15:8];
        end
        @(posedge mclk);
        cmd_ad_i <= 8'h00;
        @(posedge mclk);                                   // register updates here
        @(negedge mclk);
    endtask

    task automatic start_run(input logic [SEQ_ADDR_W:0] addr, input logic [CHN_W-1:0] chn,
                             input logic refr);
        @(posedge mclk);
        run_addr_i    <= addr;
        run_chn_i     <= chn;
        run_refresh_i <= refr;
        run_seq_i     <= 1'b1;
        @(posedge mclk);
        run_seq_i <= 1'b0;
    endtask

    task automatic wait_busy();
        int n;
        n = 0;
        @(negedge mclk);
        while (!run_busy_o) begin
            n++;
            if (n > 20)
                timed_out("run_busy_o");
            @(negedge mclk);
        end
    endtask

    // pins start 2 cycles after busy and the write side d+1 cycles after them
    task automatic build_model(input int row0, input logic pins_on, input int d);
        int r;
        int p;
        int t;
        for (t = 0; t < T_MAX; t++) begin
            e_op[t] = OP_NOP;
            e_ba[t] = '0;
            e_a[t]  = '0;
            {e_rd[t], e_pg[t], e_rpg[t], e_wr[t], e_wpg[t], e_done[t]} = '0;
        end
        p      = 0;
        r      = row0;
        done_t = -1;
        while (done_t < 0) begin
            t = p + 2;
            if (pins_on) begin
                e_op[t] = tbl_op[r];
                e_ba[t] = tbl_ba[r];
                e_a[t]  = tbl_a[r];
            end
            e_rd[t] = tbl_flg[r][2];
            e_pg[t] = tbl_flg[r][0];
            if (tbl_flg[r][1])
                mode_m = 1'b1;
            else if (tbl_flg[r][2])
                mode_m = 1'b0;
            e_rpg[t]       = tbl_flg[r][0] && !mode_m;
            e_wr[t+d+1]    = tbl_flg[r][1];
            e_wpg[t+d+1]   = tbl_flg[r][0] && mode_m;
            if (tbl_flg[r][4]) begin
                e_done[t] = 1'b1;
                done_t    = t;
            end
            p++;
            if (tbl_flg[r][3])
                p++;                                       // add-pause nop
            if (tbl_op[r] == OP_NOP)
                p += int'(tbl_a[r][9:0]);
            r++;
        end
    endtask

    task automatic run_and_check(input logic [SEQ_ADDR_W:0] addr, input int row0,
                                 input logic pins_on, input int d);
        logic [CHN_W-1:0] chn;
        logic             refr;
        chn  = CHN_W'($urandom % 16);
        refr = 1'($urandom % 2);
        build_model(row0, pins_on, d);
        start_run(addr, chn, refr);
        wait_busy();
        for (int t = 0; t <= done_t + d + 3; t++) begin
            if (t > 0)
                @(negedge mclk);
            check("pin op", {sd_ras_o, sd_cas_o, sd_we_o}, e_op[t]);
            check("sd_ba_o", sd_ba_o, e_ba[t]);
            check("sd_a_o", sd_a_o, e_a[t]);
            check("ext_buf_rd_o", ext_buf_rd_o, e_rd[t]);
            check("ext_buf_page_nxt_o", ext_buf_page_nxt_o, e_pg[t]);
            check("ext_buf_rpage_nxt_o", ext_buf_rpage_nxt_o, e_rpg[t]);
            check("ext_buf_wr_o", ext_buf_wr_o, e_wr[t]);
            check("ext_buf_wpage_nxt_o", ext_buf_wpage_nxt_o, e_wpg[t]);
            check("run_done_o", run_done_o, e_done[t]);
            check("run_busy_o", run_busy_o, t <= done_t);
            check("ext_buf_rrun_o", ext_buf_rrun_o, t == 0);
            check("ext_buf_wrun_o", ext_buf_wrun_o, t == d + 1);
            check("ext_buf_rchn_o", ext_buf_rchn_o, chn);
            check("ext_buf_rrefresh_o", ext_buf_rrefresh_o, refr);
            if (t >= d + 1) begin                          // older run values before that
                check("ext_buf_wchn_o", ext_buf_wchn_o, chn);
                check("ext_buf_wrefresh_o", ext_buf_wrefresh_o, refr);
            end
        end
        repeat (20) @(posedge mclk);                       // flush delay line
    endtask

    initial begin
        int n;
        void'($urandom(89));
        err_cnt       = 0;
        mode_m        = 1'b0;
        rst           = 1'b1;
        cmd_stb_i     = 1'b0;
        cmd_ad_i      = '0;
        mem_we_i      = 1'b0;
        mem_addr_i    = '0;
        mem_data_i    = '0;
        run_addr_i    = '0;
        run_chn_i     = '0;
        run_refresh_i = 1'b0;
        run_seq_i     = 1'b0;
        repeat (2) @(posedge mclk);
        rst <= 1'b0;

        @(negedge mclk);                                   // reset state
        check("sdrst_o", sdrst_o, 1'b0);
        check("mcontr_reset_o", mcontr_reset_o, 1'b1);
        check("sd_cke_o", sd_cke_o, 1'b0);
        check("pin op", {sd_ras_o, sd_cas_o, sd_we_o}, OP_NOP);
        check("run_busy_o", run_busy_o, 1'b0);
        load_table();
        s_addr = 1 + $urandom % 900;
        load_mem(11'h000, 0, 8);
        load_mem(11'h400 + 11'(s_addr), 8, 5);
        load_mem(11'h064, 13, 7);
        load_mem(11'h0c8, 20, 3);
        start_run(11'h000, 4'h1, 1'b0);                    // memory still in reset
        repeat (6) begin
            @(negedge mclk);
            check("run_busy_o in reset", run_busy_o, 1'b0);
        end

        write_cmd(16'h0026, 16'h0000, 1'b0);               // release sdram reset
        check("sdrst_o", sdrst_o, 1'b1);
        check("mcontr_reset_o", mcontr_reset_o, 1'b0);
        write_cmd(16'h0029, 16'h0000, 1'b0);
        check("sd_cke_o", sd_cke_o, 1'b1);
        write_cmd(16'h0025, 16'h0000, 1'b0);
        check("cmda_en", dut_i.cmda_en, 1'b1);
        write_cmd(16'h0052, 16'h0003, 1'b1);
        check("wbuf_delay", dut_i.wbuf_delay, 4'd3);
        write_cmd(16'h0107, 16'h0000, 1'b0);               // no group matches
        check("sdrst_o", sdrst_o, 1'b1);
        check("sd_cke_o", sd_cke_o, 1'b1);
        check("wbuf_delay", dut_i.wbuf_delay, 4'd3);

        run_and_check(11'h000, 0, 1'b1, 3);
        run_and_check(11'h400 + 11'(s_addr), 8, 1'b1, 3);
        write_cmd(16'h0024, 16'h0000, 1'b0);               // pins off
        run_and_check(11'h400 + 11'(s_addr), 8, 1'b0, 3);
        write_cmd(16'h0025, 16'h0000, 1'b0);

        run_and_check(11'h064, 13, 1'b1, 3);
        write_cmd(16'h0052, 16'h000b, 1'b1);
        run_and_check(11'h064, 13, 1'b1, 11);

        start_run(11'h0c8, 4'h2, 1'b0);                    // abort inside the long pause
        wait_busy();
        repeat (10) @(posedge mclk);
        write_cmd(16'h0027, 16'h0000, 1'b0);
        n = 0;
        while (!mcontr_reset_o) begin
            n++;
            if (n > 10)
                timed_out("mcontr_reset_o");
            @(negedge mclk);
        end
        check("run_busy_o before abort", run_busy_o, 1'b1);
        @(negedge mclk);
        check("run_busy_o after abort", run_busy_o, 1'b0);
        repeat (20) begin
            @(negedge mclk);
            check("run_done_o after abort", run_done_o, 1'b0);
            check("run_busy_o after abort", run_busy_o, 1'b0);
        end
        write_cmd(16'h0026, 16'h0000, 1'b0);

        if (err_cnt == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "checks failed");
        end
    end

endmodule

// ==== verilog/ddr3_seq_pkg.sv ====
package ddr3_seq_pkg;

    localparam int SEQ_ADDR_W = 10;                 // word address inside one bank
    localparam int SEQ_DEPTH  = 1 << SEQ_ADDR_W;    // words per bank
    localparam int CMD_W      = 32;                 // sequence word
    localparam int SD_ADDR_W  = 15;                 // sdram row/column address
    localparam int SD_BA_W    = 3;                  // sdram bank address
    localparam int CHN_W      = 4;                  // buffer channel number
    localparam int PAUSE_W    = 10;                 // nop pause length
    localparam int WDLY_W     = 4;                  // write buffer delay, 1..16 cycles

    // byte-serial address groups, upper address bits are don't care
    localparam logic [15:0] PHY0_BASE  = 16'h0020;  // 0-bit set/reset commands
    localparam logic [15:0] PHY0_MASK  = 16'h07f0;
    localparam logic [15:0] PHY16_BASE = 16'h0050;  // 16-bit data commands
    localparam logic [15:0] PHY16_MASK = 16'h07f8;

    localparam logic [3:0] PHY0_CMDA_EN   = 4'h4;   // pair, lsb is the new level
    localparam logic [3:0] PHY0_SDRST_ACT = 4'h6;
    localparam logic [3:0] PHY0_CKE_EN    = 4'h8;
    localparam logic [2:0] PHY16_WBUF_DELAY = 3'h2; // write buffer delay register

    localparam logic [WDLY_W-1:0] DFLT_WBUF_DELAY = 4'd8;

    // sequence word layout
    localparam int F_OP_HI     = 31;                // {ras,cas,we}, active low
    localparam int F_OP_LO     = 29;
    localparam int F_BA_LO     = 26;
    localparam int F_A_LO      = 11;                // pause length and done flag on a nop
    localparam int F_BUF_RD    = 10;
    localparam int F_BUF_WR    = 9;
    localparam int F_BUF_RST   = 8;
    localparam int F_ADD_PAUSE = 7;

    typedef enum logic [2:0] {
        OP_MRS = 3'd0,
        OP_REF = 3'd1,
        OP_PRE = 3'd2,
        OP_ACT = 3'd3,
        OP_WR  = 3'd4,
        OP_RD  = 3'd5,
        OP_ZQ  = 3'd6,
        OP_NOP = 3'd7
    } seq_op_e;

    typedef enum logic [1:0] {
        ST_IDLE,                                    // waiting for strobe with low address
        ST_ADDR_H,
        ST_DATA_L,
        ST_DATA_H
    } desr_state_e;

endpackage

// ==== verilog/ddr3_seq_top.sv ====
`timescale 1ns/1ns

module ddr3_seq_top (
    input  logic                                 mclk,
    input  logic                                 rst,
    input  logic [7:0]                           cmd_ad_i,
    input  logic                                 cmd_stb_i,
    input  logic                                 mem_we_i,
    input  logic [ddr3_seq_pkg::SEQ_ADDR_W:0]    mem_addr_i,
    input  logic [ddr3_seq_pkg::CMD_W-1:0]       mem_data_i,
    input  logic [ddr3_seq_pkg::SEQ_ADDR_W:0]    run_addr_i,
    input  logic [ddr3_seq_pkg::CHN_W-1:0]       run_chn_i,
    input  logic                                 run_refresh_i,
    input  logic                                 run_seq_i,
    output logic                                 run_busy_o,
    output logic                                 run_done_o,
    output logic                                 mcontr_reset_o,
    output logic                                 sdrst_o,        // active low
    output logic                                 sd_cke_o,
    output logic                                 sd_ras_o,
    output logic                                 sd_cas_o,
    output logic                                 sd_we_o,
    output logic [ddr3_seq_pkg::SD_BA_W-1:0]     sd_ba_o,
    output logic [ddr3_seq_pkg::SD_ADDR_W-1:0]   sd_a_o,
    output logic                                 ext_buf_rd_o,
    output logic                                 ext_buf_page_nxt_o,
    output logic                                 ext_buf_rpage_nxt_o,
    output logic [ddr3_seq_pkg::CHN_W-1:0]       ext_buf_rchn_o,
    output logic                                 ext_buf_rrefresh_o,
    output logic                                 ext_buf_rrun_o,
    output logic                                 ext_buf_wr_o,
    output logic                                 ext_buf_wpage_nxt_o,
    output logic [ddr3_seq_pkg::CHN_W-1:0]       ext_buf_wchn_o,
    output logic                                 ext_buf_wrefresh_o,
    output logic                                 ext_buf_wrun_o
);
    import ddr3_seq_pkg::*;

    logic                  cmda_en;
    logic [WDLY_W-1:0]     wbuf_delay;
    logic                  rd_en;
    logic                  rd_bank;
    logic [SEQ_ADDR_W-1:0] rd_addr;
    logic [CMD_W-1:0]      word;
    logic                  word_vld;
    logic                  buf_wr;

    assign sdrst_o = !mcontr_reset_o;                                // pin is active low

    seq_ctrl_port ctrl_i (
        .mclk(mclk), .rst(rst), .cmd_ad_i(cmd_ad_i), .cmd_stb_i(cmd_stb_i),
        .ddr_rst_o(mcontr_reset_o), .ddr_cke_o(sd_cke_o), .cmda_en_o(cmda_en),
        .wbuf_delay_o(wbuf_delay));

    seq_fetch fetch_i (
        .mclk(mclk), .rst(rst), .run_seq_i(run_seq_i), .run_addr_i(run_addr_i),
        .run_chn_i(run_chn_i), .run_refresh_i(run_refresh_i), .ddr_rst_i(mcontr_reset_o),
        .word_i(word), .word_vld_i(word_vld), .done_i(run_done_o),
        .rd_en_o(rd_en), .rd_bank_o(rd_bank), .rd_addr_o(rd_addr), .run_busy_o(run_busy_o),
        .chn_o(ext_buf_rchn_o), .refresh_o(ext_buf_rrefresh_o), .run_d_o(ext_buf_rrun_o));

    seq_cmd_mem mem_i (
        .mclk(mclk), .we_i(mem_we_i), .waddr_i(mem_addr_i), .wdata_i(mem_data_i),
        .rd_en_i(rd_en), .rd_bank_i(rd_bank), .rd_addr_i(rd_addr),
        .word_o(word), .word_vld_o(word_vld));

    seq_cmd_decode decode_i (
        .mclk(mclk), .rst(rst), .word_i(word), .word_vld_i(word_vld), .cmda_en_i(cmda_en),
        .sd_ras_o(sd_ras_o), .sd_cas_o(sd_cas_o), .sd_we_o(sd_we_o), .sd_ba_o(sd_ba_o),
        .sd_a_o(sd_a_o), .buf_rd_o(ext_buf_rd_o), .buf_wr_o(buf_wr),
        .buf_rst_o(ext_buf_page_nxt_o), .done_o(run_done_o));

    seq_wbuf_delay wdly_i (
        .mclk(mclk), .rst(rst), .wbuf_delay_i(wbuf_delay), .buf_wr_i(buf_wr),
        .buf_rst_i(ext_buf_page_nxt_o), .buf_rd_i(ext_buf_rd_o), .chn_i(ext_buf_rchn_o),
        .refresh_i(ext_buf_rrefresh_o), .run_d_i(ext_buf_rrun_o),
        .ext_buf_wr_o(ext_buf_wr_o), .ext_buf_wpage_nxt_o(ext_buf_wpage_nxt_o),
        .ext_buf_rpage_nxt_o(ext_buf_rpage_nxt_o), .ext_buf_wchn_o(ext_buf_wchn_o),
        .ext_buf_wrefresh_o(ext_buf_wrefresh_o), .ext_buf_wrun_o(ext_buf_wrun_o));

endmodule

// ==== verilog/seq_cmd_decode.sv ====
`timescale 1ns/1ns

module seq_cmd_decode (
    input  logic                                mclk,
    input  logic                                rst,
    input  logic [ddr3_seq_pkg::CMD_W-1:0]      word_i,
    input  logic                                word_vld_i,  // low on stalls, pins pad with nop
    input  logic                                cmda_en_i,
    output logic                                sd_ras_o,
    output logic                                sd_cas_o,
    output logic                                sd_we_o,
    output logic [ddr3_seq_pkg::SD_BA_W-1:0]    sd_ba_o,
    output logic [ddr3_seq_pkg::SD_ADDR_W-1:0]  sd_a_o,
    output logic                                buf_rd_o,
    output logic                                buf_wr_o,
    output logic                                buf_rst_o,
    output logic                                done_o       // run_done, first cycle of done nop
);
    import ddr3_seq_pkg::*;

    seq_op_e op;
    logic    pins_on;                                      // real word goes to the pins

    assign op      = seq_op_e'(word_i[F_OP_HI:F_OP_LO]);
    assign pins_on = word_vld_i && cmda_en_i;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            {sd_ras_o, sd_cas_o, sd_we_o} <= OP_NOP;
            sd_ba_o   <= '0;
            sd_a_o    <= '0;
            buf_rd_o  <= 1'b0;
            buf_wr_o  <= 1'b0;
            buf_rst_o <= 1'b0;
            done_o    <= 1'b0;
        end else begin
            {sd_ras_o, sd_cas_o, sd_we_o} <= pins_on ? op : OP_NOP;
            sd_ba_o   <= pins_on ? word_i[F_BA_LO +: SD_BA_W] : '0;
            sd_a_o    <= pins_on ? word_i[F_A_LO +: SD_ADDR_W] : '0;
            // buffer strobes run even with the pins disabled
            buf_rd_o  <= word_vld_i && word_i[F_BUF_RD];
            buf_wr_o  <= word_vld_i && word_i[F_BUF_WR];
            buf_rst_o <= word_vld_i && word_i[F_BUF_RST];
            done_o    <= word_vld_i && op == OP_NOP && word_i[F_A_LO + PAUSE_W];
        end
    end

endmodule

// ==== verilog/seq_cmd_mem.sv ====
`timescale 1ns/1ns

module seq_cmd_mem (
    input  logic                                 mclk,
    input  logic                                 we_i,
    input  logic [ddr3_seq_pkg::SEQ_ADDR_W:0]    waddr_i,    // msb is the bank
    input  logic [ddr3_seq_pkg::CMD_W-1:0]       wdata_i,
    input  logic                                 rd_en_i,
    input  logic                                 rd_bank_i,  // 0 manual, 1 automatic
    input  logic [ddr3_seq_pkg::SEQ_ADDR_W-1:0]  rd_addr_i,
    output logic [ddr3_seq_pkg::CMD_W-1:0]       word_o,
    output logic                                 word_vld_o  // word_o is a fresh read
);
    import ddr3_seq_pkg::*;

    logic [CMD_W-1:0] bank0 [SEQ_DEPTH];                  // manual sequences
    logic [CMD_W-1:0] bank1 [SEQ_DEPTH];                  // automatic sequences

    always_ff @(posedge mclk) begin
        if (we_i && !waddr_i[SEQ_ADDR_W])
            bank0[waddr_i[SEQ_ADDR_W-1:0]] <= wdata_i;
        if (we_i && waddr_i[SEQ_ADDR_W])
            bank1[waddr_i[SEQ_ADDR_W-1:0]] <= wdata_i;
    end

    // output holds between reads, valid marks the new word
    always_ff @(posedge mclk) begin
        if (rd_en_i)
            word_o <= rd_bank_i ? bank1[rd_addr_i] : bank0[rd_addr_i];
        word_vld_o <= rd_en_i;
    end

endmodule

// ==== verilog/seq_ctrl_port.sv ====
`timescale 1ns/1ns

module seq_ctrl_port (
    input  logic                             mclk,
    input  logic                             rst,
    input  logic [7:0]                       cmd_ad_i,     // address/data byte
    input  logic                             cmd_stb_i,    // with the low address byte
    output logic                             ddr_rst_o,    // memory reset active high
    output logic                             ddr_cke_o,
    output logic                             cmda_en_o,    // command/address pins enable
    output logic [ddr3_seq_pkg::WDLY_W-1:0]  wbuf_delay_o
);
    import ddr3_seq_pkg::*;

    desr_state_e       state;
    logic [7:0]        addr_q;                             // low address byte
    logic [15:0]       addr_w;                             // address while high byte is on the bus
    logic [WDLY_W-1:0] data_l;                             // only the delay bits are kept
    logic              we0;                                // 0-bit write one cycle after last byte
    logic              we16;                               // 16-bit write with the same timing

    assign addr_w = {cmd_ad_i, addr_q};

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            state  <= ST_IDLE;
            addr_q <= '0;
            we0    <= 1'b0;
            we16   <= 1'b0;
        end else begin
            we0  <= 1'b0;
            we16 <= 1'b0;
            if (cmd_stb_i) begin                           // strobe always restarts
                addr_q <= cmd_ad_i;
                state  <= ST_ADDR_H;
            end else begin
                case (state)
                    ST_ADDR_H: begin
                        if ((addr_w & PHY0_MASK) == PHY0_BASE) begin
                            we0   <= 1'b1;                 // no data bytes follow
                            state <= ST_IDLE;
                        end else if ((addr_w & PHY16_MASK) == PHY16_BASE) begin
                            state <= ST_DATA_L;
                        end else begin
                            state <= ST_IDLE;              // not ours so dropped
                        end
                    end
                    ST_DATA_L: state <= ST_DATA_H;
                    ST_DATA_H: begin
                        we16  <= 1'b1;
                        state <= ST_IDLE;
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    always_ff @(posedge mclk) begin
        if (state == ST_DATA_L && !cmd_stb_i)
            data_l <= cmd_ad_i[WDLY_W-1:0];                // high data byte is don't care
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            ddr_rst_o    <= 1'b1;                          // memory held in reset
            ddr_cke_o    <= 1'b0;
            cmda_en_o    <= 1'b0;
            wbuf_delay_o <= DFLT_WBUF_DELAY;
        end else begin
            if (we0 && addr_q[3:1] == PHY0_CMDA_EN[3:1])
                cmda_en_o <= addr_q[0];
            if (we0 && addr_q[3:1] == PHY0_SDRST_ACT[3:1])
                ddr_rst_o <= addr_q[0];
            if (we0 && addr_q[3:1] == PHY0_CKE_EN[3:1])
                ddr_cke_o <= addr_q[0];
            if (we16 && addr_q[2:0] == PHY16_WBUF_DELAY)
                wbuf_delay_o <= data_l;
        end
    end

endmodule

// ==== verilog/seq_fetch.sv ====
`timescale 1ns/1ns

module seq_fetch (
    input  logic                                 mclk,
    input  logic                                 rst,
    input  logic                                 run_seq_i,
    input  logic [ddr3_seq_pkg::SEQ_ADDR_W:0]    run_addr_i,   // msb selects bank
    input  logic [ddr3_seq_pkg::CHN_W-1:0]       run_chn_i,
    input  logic                                 run_refresh_i,
    input  logic                                 ddr_rst_i,    // aborts a running sequence
    input  logic [ddr3_seq_pkg::CMD_W-1:0]       word_i,
    input  logic                                 word_vld_i,
    input  logic                                 done_i,       // done nop on the pins
    output logic                                 rd_en_o,
    output logic                                 rd_bank_o,
    output logic [ddr3_seq_pkg::SEQ_ADDR_W-1:0]  rd_addr_o,
    output logic                                 run_busy_o,
    output logic [ddr3_seq_pkg::CHN_W-1:0]       chn_o,
    output logic                                 refresh_o,
    output logic                                 run_d_o       // run_seq delayed, accepted only
);
    import ddr3_seq_pkg::*;

    logic [2:0]         busy;                              // 0 fetch, 1 word out, 2 pins
    logic [PAUSE_W-1:0] pause_cnt;
    logic               stop;                              // done word seen, no more reads
    logic               start;
    logic               wv;                                // returned word belongs to this run
    logic               w_nop;
    logic               w_done;
    logic [PAUSE_W-1:0] w_len;
    logic               w_hold;                            // this word stalls the next read

    assign start  = run_seq_i && !busy[0] && !ddr_rst_i;
    assign wv     = word_vld_i && busy[1];
    assign w_nop  = word_i[F_OP_HI:F_OP_LO] == OP_NOP;
    assign w_len  = word_i[F_A_LO +: PAUSE_W];
    assign w_done = word_i[F_A_LO + PAUSE_W];
    assign w_hold = wv && (word_i[F_ADD_PAUSE] || (w_nop && (w_len != '0 || w_done)));

    // reads resume exactly when the padding on the pins runs out
    assign rd_en_o    = busy[0] && !ddr_rst_i && !stop && pause_cnt == '0 && !w_hold;
    assign run_busy_o = busy[0];

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            busy      <= '0;
            pause_cnt <= '0;
            stop      <= 1'b0;
            rd_bank_o <= 1'b0;
            rd_addr_o <= '0;
            chn_o     <= '0;
            refresh_o <= 1'b0;
            run_d_o   <= 1'b0;
        end else begin
            if (ddr_rst_i || (done_i && busy[2]))
                busy <= '0;
            else
                busy <= {busy[1:0], start || busy[0]};

            if (ddr_rst_i || !busy[1])
                pause_cnt <= '0;
            else if (wv && w_nop && w_len != '0)
                pause_cnt <= w_len - 1'b1;                 // this cycle already stalls
            else if (pause_cnt != '0)
                pause_cnt <= pause_cnt - 1'b1;

            if (ddr_rst_i || !busy[0])
                stop <= 1'b0;
            else if (wv && w_nop && w_done)
                stop <= 1'b1;

            if (start) begin
                rd_bank_o <= run_addr_i[SEQ_ADDR_W];
                rd_addr_o <= run_addr_i[SEQ_ADDR_W-1:0];
                chn_o     <= run_chn_i;
                refresh_o <= run_refresh_i;
            end else if (rd_en_o) begin
                rd_addr_o <= rd_addr_o + 1'b1;
            end
            run_d_o <= start;
        end
    end

endmodule

// ==== verilog/seq_wbuf_delay.sv ====
`timescale 1ns/1ns

module seq_wbuf_delay (
    input  logic                              mclk,
    input  logic                              rst,
    input  logic [ddr3_seq_pkg::WDLY_W-1:0]   wbuf_delay_i,  // tap, delay is value + 1
    input  logic                              buf_wr_i,
    input  logic                              buf_rst_i,
    input  logic                              buf_rd_i,
    input  logic [ddr3_seq_pkg::CHN_W-1:0]    chn_i,
    input  logic                              refresh_i,
    input  logic                              run_d_i,
    output logic                              ext_buf_wr_o,
    output logic                              ext_buf_wpage_nxt_o,
    output logic                              ext_buf_rpage_nxt_o,
    output logic [ddr3_seq_pkg::CHN_W-1:0]    ext_buf_wchn_o,
    output logic                              ext_buf_wrefresh_o,
    output logic                              ext_buf_wrun_o
);
    import ddr3_seq_pkg::*;

    logic                                  mem_rd_mode;   // last strobe was buf_wr
    logic                                  mode_nxt;      // includes the current word
    logic [CHN_W+3:0]                      dly_in;
    logic [CHN_W+3:0]                      dly_out;
    logic [(CHN_W+4)*(1<<WDLY_W)-1:0]      dly_sr;        // stage 0 is one cycle late

    assign mode_nxt = buf_wr_i ? 1'b1 : (buf_rd_i ? 1'b0 : mem_rd_mode);
    assign ext_buf_rpage_nxt_o = buf_rst_i && !mode_nxt;  // page reset on the read side

    always_ff @(posedge mclk or posedge rst) begin
        if (rst)
            mem_rd_mode <= 1'b0;
        else
            mem_rd_mode <= mode_nxt;
    end

    assign dly_in = {buf_wr_i, buf_rst_i && mode_nxt, run_d_i, refresh_i, chn_i};

    always_ff @(posedge mclk or posedge rst) begin
        if (rst)
            dly_sr <= '0;
        else
            dly_sr <= {dly_sr[(CHN_W+4)*((1<<WDLY_W)-1)-1:0], dly_in};
    end

    assign dly_out = dly_sr[wbuf_delay_i*(CHN_W+4) +: CHN_W+4];

    assign ext_buf_wr_o        = dly_out[CHN_W+3];
    assign ext_buf_wpage_nxt_o = dly_out[CHN_W+2];
    assign ext_buf_wrun_o      = dly_out[CHN_W+1];
    assign ext_buf_wrefresh_o  = dly_out[CHN_W];
    assign ext_buf_wchn_o      = dly_out[CHN_W-1:0];

endmodule
